/* iopage.f */
src/iopage_bus_pkg.sv
src/iopage_map_pkg.sv
src/iopage_mux.sv
src/line_clock.sv
src/console_tx.sv
src/switch_regs.sv
src/iopage.sv
tb/iopage_tb.sv

/* run.sh */
#!/bin/sh
# Builds the I/O page testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
   verilator --binary --timing --timescale 1ns/1ps --top-module iopage_tb \
      -f iopage.f -o iopage_sim &&
   ./obj_dir/iopage_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" ||
   { echo "Simulation failed."; exit 1; }
echo "Simulation passed."

/* tb/iopage_tb.sv */
`timescale 1ns/1ps
// I/O page testbench.
// Random bus traffic against a model, with a serial receiver on rs232_tx.
module iopage_tb;

   localparam int tick_div     = 50;
   localparam int baud_div     = 4;
   localparam int period       = 20;
   localparam int bit_ns       = baud_div * period;
   localparam int n_sw         = 16;
   localparam int n_disp       = 24;
   localparam int n_nodec      = 24;
   localparam int n_chars      = 8;
   localparam int n_txn        = n_sw + n_disp + n_nodec + 4 * n_chars + 8;
   localparam int frame_cycles = 10 * baud_div + 4;  // Longest frame with margin.
   localparam int limit_ns     = (10 + tick_div + n_txn * frame_cycles + 200) * period;

   logic                         clk = 1'b0;
   logic                         rst_n;
   iopage_bus_pkg::iopage_req_t  req;
   iopage_bus_pkg::word_t        switches;
   iopage_bus_pkg::word_t        rdata;
   logic                         no_decode;
   logic                         interrupt;
   iopage_bus_pkg::vector_t      vector;
   iopage_bus_pkg::word_t        display;
   logic                         rs232_tx;

   integer                       seed = 13068;
   iopage_bus_pkg::word_t        display_m;
   logic [7:0]                   exp_q[$];  // Bytes written and not yet received.
   int                           rx_count = 0;

   iopage #(
      .tick_div (tick_div),
      .baud_div (baud_div)
   ) iopage_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .switches  (switches),
      .rdata     (rdata),
      .no_decode (no_decode),
      .interrupt (interrupt),
      .vector    (vector),
      .display   (display),
      .rs232_tx  (rs232_tx)
   );

   always #(period / 2) clk = ~clk;

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped on error.");
   endtask

   task automatic check_word(input iopage_bus_pkg::word_t got, exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_vector(input iopage_bus_pkg::vector_t got, exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("MISMATCH at %0t ns: %s got %o, expected %o",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("MISMATCH at %0t ns: %s got %b, expected %b",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_byte(input logic [7:0] got, exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                                 $time, what, got, exp));
      end
   endtask

   function automatic logic is_reg_addr(input iopage_bus_pkg::iopage_addr_t a);
      return a[12:1] == iopage_map_pkg::clk_csr_addr[12:1] ||
             a[12:1] == iopage_map_pkg::tt_xcsr_addr[12:1] ||
             a[12:1] == iopage_map_pkg::tt_xbuf_addr[12:1] ||
             a[12:1] == iopage_map_pkg::sr_addr[12:1];
   endfunction

   // One bus cycle. Starts 2 ns after a rising edge and ends 2 ns after the next.
   task automatic access(input iopage_bus_pkg::iopage_addr_t addr,
                         input iopage_bus_pkg::word_t wdata,
                         input logic rd, wr, byte_op,
                         output iopage_bus_pkg::word_t rd_data,
                         output logic nd);
      req.addr    = addr;
      req.wdata   = wdata;
      req.rd      = rd;
      req.wr      = wr;
      req.byte_op = byte_op;
      @(negedge clk);  // Combinational read path has settled.
      rd_data = rdata;
      nd      = no_decode;
      @(posedge clk);
      #2;
      req.rd = 1'b0;
      req.wr = 1'b0;
   endtask

   // Serial receiver, samples near each bit centre.
   initial begin
      logic [7:0] rx_byte;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge rs232_tx);
         #(bit_ns / 2 + 5);
         check_bit(rs232_tx, 1'b0, "start bit");
         for (int i = 0; i < 8; i++) begin
            #(bit_ns);
            rx_byte[i] = rs232_tx;  // LSB first.
         end
         #(bit_ns);
         check_bit(rs232_tx, 1'b1, "stop bit");
         if (exp_q.size() == 0) begin
            stop_on_error("A serial frame arrived with no byte written to XBUF.");
         end else begin
            check_byte(rx_byte, exp_q.pop_front(), "received serial byte");
            rx_count++;
         end
      end
   end

   initial begin
      #(limit_ns);
      stop_on_error("Watchdog timeout: the test did not finish in the expected time.");
   end

   initial begin
      iopage_bus_pkg::word_t        rd_data;
      iopage_bus_pkg::word_t        wdata;
      iopage_bus_pkg::iopage_addr_t addr;
      logic [31:0]                  rnd;
      logic                         nd;
      logic                         rd;
      logic                         wr;
      logic                         bo;
      int                           polls;
      rst_n     = 1'b0;
      req       = '0;
      switches  = '0;
      display_m = '0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_bit(rs232_tx, 1'b1, "rs232_tx after reset");
      check_bit(interrupt, 1'b0, "interrupt after reset");
      check_word(display, 16'h0000, "display after reset");
      access(iopage_map_pkg::tt_xcsr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
      check_word(rd_data, 16'o200, "XCSR after reset");

      repeat (n_sw) begin
         rnd      = $random(seed);
         switches = rnd[15:0];
         access(iopage_map_pkg::sr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
         check_word(rd_data, rnd[15:0], "switch register read");
         check_bit(nd, 1'b0, "no_decode on switch read");
      end

      repeat (n_disp) begin
         rnd   = $random(seed);
         wdata = rnd[15:0];
         bo    = rnd[17];
         addr  = {iopage_map_pkg::sr_addr[12:1], rnd[16]};
         if (!bo || !addr[0]) display_m[7:0] = wdata[7:0];
         if (!bo || addr[0]) display_m[15:8] = wdata[15:8];
         access(addr, wdata, 1'b0, 1'b1, bo, rd_data, nd);
         check_word(display, display_m, "display after write");
      end

      repeat (n_nodec) begin
         rnd  = $random(seed);
         addr = rnd[12:0];
         while (is_reg_addr(addr)) begin
            rnd  = $random(seed);
            addr = rnd[12:0];
         end
         rd = rnd[13];
         wr = rnd[14];
         bo = rnd[15];
         access(addr, rnd[31:16], rd, wr, bo, rd_data, nd);
         check_word(rd_data, 16'h0000, "rdata on unclaimed address");
         check_bit(nd, rd | wr, "no_decode on unclaimed address");
      end
      check_word(display, display_m, "display after unclaimed writes");

      repeat (n_chars) begin
         rnd = $random(seed);
         exp_q.push_back(rnd[7:0]);
         access(iopage_map_pkg::tt_xbuf_addr, {8'h00, rnd[7:0]}, 1'b0, 1'b1, 1'b0, rd_data, nd);
         // Transmitter is busy, this byte must be lost.
         access(iopage_map_pkg::tt_xbuf_addr, {8'h00, rnd[15:8]}, 1'b0, 1'b1, 1'b0, rd_data, nd);
         access(iopage_map_pkg::tt_xbuf_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
         check_word(rd_data, 16'h0000, "XBUF read");
         access(iopage_map_pkg::tt_xcsr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
         check_word(rd_data, 16'o000, "XCSR during frame");
         polls = 0;
         while (!rd_data[7]) begin
            if (polls > 20 * baud_div) begin
               stop_on_error("Console ready did not come back after a frame.");
            end else begin
               access(iopage_map_pkg::tt_xcsr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
               polls++;
            end
         end
         check_word(rd_data, 16'o200, "XCSR after frame");
      end

      // Clock ie on. Flag bit zero also clears the old monitor flag.
      access(iopage_map_pkg::clk_csr_addr, 16'o100, 1'b0, 1'b1, 1'b0, rd_data, nd);
      polls = 0;
      while (interrupt !== 1'b1) begin
         if (polls > tick_div + 2) begin
            stop_on_error("The line clock interrupt did not rise within one tick period.");
         end else begin
            @(posedge clk);
            #2;
            polls++;
         end
      end
      check_vector(vector, 8'o100, "line clock vector");
      access(iopage_map_pkg::clk_csr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
      check_word(rd_data, 16'o300, "line clock CSR");
      access(iopage_map_pkg::tt_xcsr_addr, 16'o100, 1'b0, 1'b1, 1'b0, rd_data, nd);
      check_bit(interrupt, 1'b1, "interrupt with both requests");
      check_vector(vector, 8'o64, "console vector has priority");
      access(iopage_map_pkg::tt_xcsr_addr, 16'o000, 1'b0, 1'b1, 1'b0, rd_data, nd);
      check_bit(interrupt, 1'b1, "interrupt with console ie off");
      check_vector(vector, 8'o100, "line clock vector after console ie off");
      // The next tick is still far off.
      access(iopage_map_pkg::clk_csr_addr, 16'o100, 1'b0, 1'b1, 1'b0, rd_data, nd);
      check_bit(interrupt, 1'b0, "interrupt after clearing the clock flag");
      access(iopage_map_pkg::clk_csr_addr, '0, 1'b1, 1'b0, 1'b0, rd_data, nd);
      check_word(rd_data, 16'o100, "line clock CSR after flag clear");
      access(iopage_map_pkg::clk_csr_addr, 16'o000, 1'b0, 1'b1, 1'b0, rd_data, nd);
      check_bit(interrupt, 1'b0, "interrupt after clearing");
      check_vector(vector, 8'o000, "vector after clearing");

      if (exp_q.size() != 0 || rx_count != n_chars) begin
         stop_on_error("The serial receiver did not see every byte written to XBUF.");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

/* src/iopage.sv */
`timescale 1ns/1ps
// I/O page top level.
// Line clock, console transmitter and switch registers behind one read mux.
module iopage #(
   parameter int tick_div = 50,
   parameter int baud_div = 4
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  iopage_bus_pkg::iopage_req_t req,
   input  iopage_bus_pkg::word_t       switches,
   output iopage_bus_pkg::word_t       rdata,
   output logic                        no_decode,
   output logic                        interrupt,
   output iopage_bus_pkg::vector_t     vector,
   output iopage_bus_pkg::word_t       display,
   output logic                        rs232_tx
);

   iopage_bus_pkg::dev_resp_t tt_resp;
   iopage_bus_pkg::dev_resp_t clk_resp;
   iopage_bus_pkg::dev_resp_t sr_resp;

   line_clock #(
      .tick_div (tick_div)
   ) line_clock_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .resp  (clk_resp)
   );

   console_tx #(
      .baud_div (baud_div)
   ) console_tx_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .resp     (tt_resp),
      .rs232_tx (rs232_tx)
   );

   switch_regs switch_regs_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .switches (switches),
      .resp     (sr_resp),
      .display  (display)
   );

   // Read data and interrupt resolution.
   iopage_mux iopage_mux_i (
      .tt_resp   (tt_resp),
      .clk_resp  (clk_resp),
      .sr_resp   (sr_resp),
      .req       (req),
      .rdata     (rdata),
      .no_decode (no_decode),
      .interrupt (interrupt),
      .vector    (vector)
   );

endmodule

/* src/switch_regs.sv */
`timescale 1ns/1ps
// Switch and display registers.
// Reads return the front panel switches, writes load the display lights.
module switch_regs (
   input  logic                        clk,
   input  logic                        rst_n,
   input  iopage_bus_pkg::iopage_req_t req,
   input  iopage_bus_pkg::word_t       switches,
   output iopage_bus_pkg::dev_resp_t   resp,
   output iopage_bus_pkg::word_t       display
);

   logic decode;
   logic lo_we;
   logic hi_we;

   assign decode = (req.addr[12:1] == iopage_map_pkg::sr_addr[12:1]);

   // Byte lanes, address bit 0 picks the half on byte writes.
   assign lo_we = decode & req.wr & (~req.byte_op | ~req.addr[0]);
   assign hi_we = decode & req.wr & (~req.byte_op | req.addr[0]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         display <= '0;
      end else begin
         if (lo_we) begin
            display[7:0] <= req.wdata[7:0];
         end
         if (hi_we) begin
            display[15:8] <= req.wdata[15:8];
         end
      end
   end

   assign resp.decode = decode;
   assign resp.rdata  = switches;  // Live value, not latched.
   assign resp.irq    = 1'b0;

endmodule

/* src/console_tx.sv */
`timescale 1ns/1ps
// Console transmitter.
// XCSR and XBUF registers and a serializer that sends 8N1 frames on rs232_tx.
module console_tx #(
   parameter int baud_div = 4
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  iopage_bus_pkg::iopage_req_t req,
   output iopage_bus_pkg::dev_resp_t   resp,
   output logic                        rs232_tx
);

   localparam int tmr_w = $clog2(baud_div);
   localparam logic [tmr_w-1:0] tmr_max = tmr_w'(baud_div - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } tx_state_t;

   tx_state_t             state;
   logic [tmr_w-1:0]      bit_tmr;
   logic [2:0]            bit_idx;
   logic                  bit_end;
   logic [7:0]            xbuf;
   logic                  ie;
   logic                  ready;
   logic                  xcsr_sel;
   logic                  xbuf_sel;
   logic                  lo_lane;
   logic                  xbuf_wr;
   iopage_bus_pkg::word_t xcsr;

   assign xcsr_sel = (req.addr[12:1] == iopage_map_pkg::tt_xcsr_addr[12:1]);
   assign xbuf_sel = (req.addr[12:1] == iopage_map_pkg::tt_xbuf_addr[12:1]);
   assign lo_lane  = ~req.byte_op | ~req.addr[0];

   assign ready   = (state == st_idle);
   assign xbuf_wr = xbuf_sel & req.wr & lo_lane & ready;  // Dropped while busy.
   assign bit_end = (bit_tmr == tmr_max);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ie <= 1'b0;
      end else if (xcsr_sel && req.wr && lo_lane) begin
         ie <= req.wdata[iopage_map_pkg::ie_bit];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_idle;
         bit_tmr <= '0;
         bit_idx <= '0;
      end else begin
         if (state == st_idle || bit_end) begin
            bit_tmr <= '0;
         end else begin
            bit_tmr <= bit_tmr + 1'b1;
         end
         case (state)
            st_idle: begin
               if (xbuf_wr) begin
                  state <= st_start;
               end
            end
            st_start: begin
               if (bit_end) begin
                  state   <= st_data;
                  bit_idx <= '0;
               end
            end
            st_data: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= st_stop;
                  end
               end
            end
            default: begin
               if (bit_end) begin
                  state <= st_idle;  // Ten bit times done.
               end
            end
         endcase
      end
   end

   // Character shifts out LSB first.
   always_ff @(posedge clk) begin
      if (xbuf_wr) begin
         xbuf <= req.wdata[7:0];
      end else if (state == st_data && bit_end) begin
         xbuf <= {1'b0, xbuf[7:1]};
      end
   end

   always_comb begin
      case (state)
         st_start: rs232_tx = 1'b0;
         st_data:  rs232_tx = xbuf[0];
         default:  rs232_tx = 1'b1;  // Idle and stop are marking.
      endcase
   end

   always_comb begin
      xcsr = '0;
      xcsr[iopage_map_pkg::ie_bit]   = ie;
      xcsr[iopage_map_pkg::flag_bit] = ready;
   end

   assign resp.decode = xcsr_sel | xbuf_sel;
   assign resp.rdata  = xcsr_sel ? xcsr : '0;  // XBUF reads back zero.
   assign resp.irq    = ready & ie;

endmodule

/* src/line_clock.sv */
`timescale 1ns/1ps
// Line clock.
// Divides the system clock to the line rate and sets the monitor flag each tick.
module line_clock #(
   parameter int tick_div = 50
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  iopage_bus_pkg::iopage_req_t req,
   output iopage_bus_pkg::dev_resp_t   resp
);

   localparam int cnt_w = $clog2(tick_div);
   localparam logic [cnt_w-1:0] cnt_max = cnt_w'(tick_div - 1);

   logic [cnt_w-1:0]      tick_cnt;
   logic                  tick;
   logic                  decode;
   logic                  csr_wr;
   logic                  ie;
   logic                  flag;
   iopage_bus_pkg::word_t csr;

   assign tick   = (tick_cnt == cnt_max);
   assign decode = (req.addr[12:1] == iopage_map_pkg::clk_csr_addr[12:1]);
   // Only the low byte holds anything.
   assign csr_wr = decode & req.wr & (~req.byte_op | ~req.addr[0]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ie   <= 1'b0;
         flag <= 1'b0;
      end else begin
         if (csr_wr) begin
            ie <= req.wdata[iopage_map_pkg::ie_bit];
         end
         if (tick) begin
            flag <= 1'b1;  // A new tick beats a clear.
         end else if (csr_wr && !req.wdata[iopage_map_pkg::flag_bit]) begin
            flag <= 1'b0;
         end
      end
   end

   always_comb begin
      csr = '0;
      csr[iopage_map_pkg::ie_bit]   = ie;
      csr[iopage_map_pkg::flag_bit] = flag;
   end

   assign resp.decode = decode;
   assign resp.rdata  = csr;
   assign resp.irq    = flag & ie;

endmodule

/* src/iopage_mux.sv */
`timescale 1ns/1ps
// I/O page read mux.
// Picks read data from the decoding device, flags unclaimed accesses and
// resolves the interrupt request with its vector.
module iopage_mux (
   input  iopage_bus_pkg::dev_resp_t   tt_resp,
   input  iopage_bus_pkg::dev_resp_t   clk_resp,
   input  iopage_bus_pkg::dev_resp_t   sr_resp,
   input  iopage_bus_pkg::iopage_req_t req,
   output iopage_bus_pkg::word_t       rdata,
   output logic                        no_decode,
   output logic                        interrupt,
   output iopage_bus_pkg::vector_t     vector
);

   logic any_decode;

   // First decoding device wins.
   always_comb begin
      if (tt_resp.decode) begin
         rdata = tt_resp.rdata;
      end else if (clk_resp.decode) begin
         rdata = clk_resp.rdata;
      end else if (sr_resp.decode) begin
         rdata = sr_resp.rdata;
      end else begin
         rdata = '0;
      end
   end

   assign any_decode = tt_resp.decode | clk_resp.decode | sr_resp.decode;
   assign no_decode  = (req.rd | req.wr) & ~any_decode;  // Bus error to the CPU.

   assign interrupt = tt_resp.irq | clk_resp.irq | sr_resp.irq;

   // Console outranks the line clock.
   always_comb begin
      if (tt_resp.irq) begin
         vector = iopage_map_pkg::tt_vector;
      end else if (clk_resp.irq) begin
         vector = iopage_map_pkg::clk_vector;
      end else begin
         vector = '0;
      end
   end

endmodule

/* src/iopage_map_pkg.sv */
// I/O page register map.
// Register offsets, interrupt vectors and status bit positions.
package iopage_map_pkg;

   // Register offsets within the page.
   localparam iopage_bus_pkg::iopage_addr_t clk_csr_addr = 13'o17546;  // Line clock CSR.
   localparam iopage_bus_pkg::iopage_addr_t tt_xcsr_addr = 13'o17564;  // Console XCSR.
   localparam iopage_bus_pkg::iopage_addr_t tt_xbuf_addr = 13'o17566;  // Console XBUF.
   localparam iopage_bus_pkg::iopage_addr_t sr_addr      = 13'o17570;  // Switches / display.

   // Interrupt vectors.
   localparam iopage_bus_pkg::vector_t clk_vector = 8'o100;
   localparam iopage_bus_pkg::vector_t tt_vector  = 8'o64;

   // Status register bits, common to both CSRs.
   localparam int ie_bit   = 6;  // Interrupt enable.
   localparam int flag_bit = 7;  // Done or monitor.

endpackage

/* src/iopage_bus_pkg.sv */
// I/O page bus types.
// Request, per-device response and the data widths shared by all blocks.
package iopage_bus_pkg;

   typedef logic [15:0] word_t;         // Bus data word.
   typedef logic [12:0] iopage_addr_t;  // Byte offset within the 8 KB page.
   typedef logic [7:0]  vector_t;       // Interrupt vector.

   // One bus cycle from the master.
   typedef struct packed {
      iopage_addr_t addr;
      word_t        wdata;
      logic         rd;
      logic         wr;
      logic         byte_op;
   } iopage_req_t;

   // Answer of a single device to the current address.
   typedef struct packed {
      logic  decode;
      word_t rdata;
      logic  irq;
   } dev_resp_t;

endpackage
